// ==== tests/pm_control_golden.txt ====
// cmd pc r15 prev_id pub_start pub_end sec_start sec_end id found caller irq dest data stat_z
// cmd 1 identity, 2 previous caller, 3 disable; irq ffff means no interrupt
0001 0100 0204 0007 0200 0240 0300 0320 0003 0001 0000 ffff 8000 0003 0000
0001 0100 0350 0007 0200 0240 0300 0320 0004 0000 0001 ffff 8000 0000 0000
0002 0100 0204 0009 0200 0240 0300 0320 0003 0000 0000 ffff 8000 0009 0000
0002 0222 0204 0002 0200 0240 0300 0320 0005 0001 0001 ffff 8000 0002 0000
0003 0208 1234 0001 0200 0210 0300 0308 0006 0000 0001 ffff 0001 1234 0000
0003 0500 4321 0001 0200 0210 0300 0308 0006 0001 0000 ffff 8000 0000 0000
0003 0410 beef 0003 0400 0440 0480 04a0 0007 0000 0001 ffff 0001 beef 0000
0003 0504 5555 0003 0500 0520 0600 0610 0008 0000 0001 0005 8000 0000 0001
0001 0600 0612 0003 0600 0640 0700 0720 0011 0001 0001 ffff 8000 0011 0000
0003 0104 aaaa 0003 0100 0130 0140 0150 0009 0000 0001 0008 8000 0000 0001
0002 0000 0000 00ab 0100 0130 0140 0150 0009 0000 0000 ffff 8000 00ab 0000
0003 0700 0042 0004 0700 0702 0710 0712 000a 0000 0001 ffff 0001 0042 0000
0001 0330 0330 0004 0300 0340 0380 0390 0012 0001 0000 ffff 8000 0012 0000

// ==== pm_control.f ====
design/pm_pkg.sv
design/range_walker.sv
design/sm_select.sv
design/result_writer.sv
design/control_fsm.sv
design/pm_control.sv
tests/pm_control_sva.sv
tests/pm_control_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pm_control_tb
RTL_TOP   ?= pm_control
FILELIST  ?= pm_control.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/pm_control_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pm_control_tb;

    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 18746;
    localparam int CMD_MARGIN = 24;
    localparam int FIELDS     = 15;
    localparam int MAX_CMDS   = 32;
    localparam int MEM_WORDS  = 1024;

    logic            clk;
    logic            reset;
    logic            start;
    logic            cmd_id;
    logic            cmd_id_prev;
    logic            cmd_disable;
    logic            irq_pnd;
    pm_pkg::word_t   pc;
    pm_pkg::word_t   r15;
    pm_pkg::word_t   sm_data;
    pm_pkg::word_t   sm_prev_id;
    logic            sm_data_select_valid;
    logic            caller_valid;
    logic            busy;
    pm_pkg::sm_req_t sm_request;
    pm_pkg::word_t   sm_data_select;
    logic            mb_en;
    logic [1:0]      mb_wr;
    pm_pkg::addr_t   mab;
    pm_pkg::word_t   data_out;
    logic            reg_write;
    pm_pkg::word_t   dest_reg;
    pm_pkg::word_t   reg_data_out;
    logic            stat_z;
    logic            stat_wr;

    logic [15:0]   golden [0:FIELDS*MAX_CMDS-1];
    logic [15:0]   mem [0:MEM_WORDS-1];
    pm_pkg::addr_t wr_log [$];
    pm_pkg::word_t tbl_pub_s;
    pm_pkg::word_t tbl_pub_e;
    pm_pkg::word_t tbl_sec_s;
    pm_pkg::word_t tbl_sec_e;
    pm_pkg::word_t tbl_id;
    int            errors;
    int            checks;
    int            n_cmds;
    int            timeout_cycles;
    logic          loaded;

    pm_control u_dut (
        .clk(clk), .reset(reset), .start(start), .cmd_id(cmd_id),
        .cmd_id_prev(cmd_id_prev), .cmd_disable(cmd_disable), .irq_pnd(irq_pnd),
        .pc(pc), .r15(r15), .sm_data(sm_data), .sm_prev_id(sm_prev_id),
        .sm_data_select_valid(sm_data_select_valid), .caller_valid(caller_valid),
        .busy(busy), .sm_request(sm_request), .sm_data_select(sm_data_select),
        .mb_en(mb_en), .mb_wr(mb_wr), .mab(mab), .data_out(data_out),
        .reg_write(reg_write), .dest_reg(dest_reg), .reg_data_out(reg_data_out),
        .stat_z(stat_z), .stat_wr(stat_wr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // module table answers the field named by sm_request
    always_comb
    begin
        case (sm_request)
            pm_pkg::REQ_PUB_START: sm_data = tbl_pub_s;
            pm_pkg::REQ_PUB_END:   sm_data = tbl_pub_e;
            pm_pkg::REQ_SEC_START: sm_data = tbl_sec_s;
            pm_pkg::REQ_SEC_END:   sm_data = tbl_sec_e;
            pm_pkg::REQ_ID:        sm_data = tbl_id;
            default:               sm_data = 16'h0000;
        endcase
    end

    // memory model, pre-edge values are the ones the write uses
    always @(posedge clk)
    begin
        if (!reset && mb_en && mb_wr != 2'b00)
        begin
            if (mb_wr != 2'b11 || data_out != 16'h0000)
            begin
                errors++;
                $display("ERROR t=%0t data_out: expected 0000 got %h (mb_wr %b)",
                         $time, data_out, mb_wr);
            end
            mem[mab[10:1]] = data_out;
            wr_log.push_back(mab);
        end
    end

    function automatic pm_pkg::word_t fill_word(input int i);
        logic [15:0] w;
        w = i[15:0] * 16'h9e37;
        return w ^ 16'h3c5a;
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i);
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR t=%0t %s: expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            check_word("busy", 16'h0, {15'h0, busy});
            check_word("mb_en", 16'h0, {15'h0, mb_en});
            check_word("reg_write", 16'h0, {15'h0, reg_write});
        end
    endtask

    task automatic run_command(input int c);
        int            base;
        int            cycles;
        int            budget;
        logic [15:0]   cmd;
        logic [15:0]   irq_at;
        logic          aborted;
        logic          in_range;
        pm_pkg::addr_t a;
        pm_pkg::addr_t exp_q [$];
        pm_pkg::word_t exp_mem;
        base   = c * FIELDS;
        cmd    = golden[base];
        irq_at = golden[base+11];
        if (irq_at != 16'hffff)
            irq_at = irq_at + 16'($urandom % 4);
        aborted = (irq_at != 16'hffff);
        // expected clear order, code range first
        if (cmd == 16'd3 && golden[base+10][0])
        begin
            for (a = golden[base+4]; a < golden[base+5]; a = a + 2)
                exp_q.push_back(a);
            for (a = golden[base+6]; a < golden[base+7]; a = a + 2)
                exp_q.push_back(a);
        end
        wr_log.delete();
        @(negedge clk);
        start                = 1'b1;
        cmd_id               = (cmd == 16'd1);
        cmd_id_prev          = (cmd == 16'd2);
        cmd_disable          = (cmd == 16'd3);
        pc                   = golden[base+1];
        r15                  = golden[base+2];
        sm_prev_id           = golden[base+3];
        tbl_pub_s            = golden[base+4];
        tbl_pub_e            = golden[base+5];
        tbl_sec_s            = golden[base+6];
        tbl_sec_e            = golden[base+7];
        tbl_id               = golden[base+8];
        sm_data_select_valid = golden[base+9][0];
        caller_valid         = golden[base+10][0];
        cycles = 0;
        budget = exp_q.size() + CMD_MARGIN;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles == 1)
                start = 1'b0;
            if (aborted && cycles == int'(irq_at))
                irq_pnd = 1'b1;
        end
        while (!reg_write && cycles < budget);
        if (!reg_write)
        begin
            errors++;
            $display("ERROR: command %0d gave no reg_write within %0d cycles", c, budget);
        end
        else
        begin
            check_word("dest_reg", golden[base+12], dest_reg);
            check_word("reg_data_out", golden[base+13], reg_data_out);
            check_word("stat_z", golden[base+14], {15'h0, stat_z});
            check_word("stat_wr", 16'h1, {15'h0, stat_wr});
            if (cmd != 16'd3)
                check_word("reg_write latency", 16'd3, cycles[15:0]);
        end
        // identity looks up r15, disable looks up the caller pc
        if (cmd == 16'd1)
            check_word("sm_data_select", golden[base+2], sm_data_select);
        else if (cmd == 16'd3)
            check_word("sm_data_select", golden[base+1], sm_data_select);
        irq_pnd     = 1'b0;
        cmd_id      = 1'b0;
        cmd_id_prev = 1'b0;
        cmd_disable = 1'b0;
        @(negedge clk);
        check_word("busy", 16'h0, {15'h0, busy});
        check_word("reg_write", 16'h0, {15'h0, reg_write});
        if (aborted)
        begin
            if (wr_log.size() >= exp_q.size())
            begin
                errors++;
                $display("ERROR: irq in command %0d did not cut the clear short", c);
            end
        end
        else
            check_word("write count", 16'(exp_q.size()), 16'(wr_log.size()));
        for (int i = 0; i < wr_log.size() && i < exp_q.size(); i++)
            check_word("mab", exp_q[i], wr_log[i]);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            a        = pm_pkg::addr_t'(i * 2);
            in_range = exp_q.size() > 0 &&
                       ((a >= tbl_pub_s && a < tbl_pub_e) || (a >= tbl_sec_s && a < tbl_sec_e));
            exp_mem  = in_range ? 16'h0000 : fill_word(i);
            if (!(in_range && aborted) && mem[i] !== exp_mem)
            begin
                errors++;
                $display("ERROR t=%0t mem[%h]: expected %h got %h", $time, a, exp_mem, mem[i]);
            end
        end
        fill_memory();
        idle_cycles(1 + int'($urandom % 4));
    endtask

    initial
    begin
        wait (loaded);
        #(timeout_cycles * CLK_PERIOD);
        errors++;
        $display("ERROR: watchdog expired before the command sequence finished");
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        int seed_val;
        seed_val             = $urandom(SEED);
        reset                = 1'b1;
        start                = 1'b0;
        cmd_id               = 1'b0;
        cmd_id_prev          = 1'b0;
        cmd_disable          = 1'b0;
        irq_pnd              = 1'b0;
        pc                   = '0;
        r15                  = '0;
        sm_prev_id           = '0;
        sm_data_select_valid = 1'b0;
        caller_valid         = 1'b0;
        tbl_pub_s            = '0;
        tbl_pub_e            = '0;
        tbl_sec_s            = '0;
        tbl_sec_e            = '0;
        tbl_id               = '0;
        errors               = 0;
        checks               = 0;
        n_cmds               = 0;
        loaded               = 1'b0;
        for (int i = 0; i < FIELDS * MAX_CMDS; i++)
            golden[i] = 16'h0000;
        $readmemh("tests/pm_control_golden.txt", golden);
        // a zero command word ends the list
        while (n_cmds < MAX_CMDS && golden[n_cmds*FIELDS] != 16'h0000)
            n_cmds++;
        timeout_cycles = 40;
        for (int c = 0; c < n_cmds; c++)
            timeout_cycles += CMD_MARGIN + 8 + (golden[c*FIELDS+5] - golden[c*FIELDS+4]) / 2
                              + (golden[c*FIELDS+7] - golden[c*FIELDS+6]) / 2;
        loaded = 1'b1;
        if (n_cmds == 0)
        begin
            errors++;
            $display("ERROR: golden file holds no commands");
        end
        fill_memory();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        idle_cycles(5);
        check_word("sm_request", 16'(pm_pkg::REQ_NONE), 16'(sm_request));
        for (int c = 0; c < n_cmds; c++)
            run_command(c);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/pm_control_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module pm_control_sva (
    input wire                      clk,
    input wire                      reset,
    input wire                      start,
    input wire                      busy,
    input wire                      mb_en,
    input wire [1:0]                mb_wr,
    input wire                      set_result,
    input wire pm_pkg::ctrl_state_t state
);

    // write strobes only inside a running command
    a_wr_needs_en: assert property (@(posedge clk) disable iff (reset)
        (mb_wr != 2'b00) |-> (mb_en && busy))
        else $error("mb_wr active without mb_en or outside a command");

    // result pulse feeds reg_write
    a_result_pulse: assert property (@(posedge clk) disable iff (reset)
        set_result |=> !set_result)
        else $error("result pulse longer than one cycle");

    a_idle_after_reset: assert property (@(posedge clk)
        reset |=> !busy)
        else $error("busy high after reset");

    a_idle_needs_start: assert property (@(posedge clk) disable iff (reset)
        (state == pm_pkg::IDLE && !start) |=> (state == pm_pkg::IDLE))
        else $error("FSM left IDLE without start");

endmodule

bind control_fsm pm_control_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .busy       (busy),
    .mb_en      (mb_en),
    .mb_wr      (mb_wr),
    .set_result (set_result),
    .state      (state)
);

`default_nettype wire

// ==== design/pm_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module pm_control (
    input  wire                clk,
    input  wire                reset,
    input  wire                start,
    input  wire                cmd_id,
    input  wire                cmd_id_prev,
    input  wire                cmd_disable,
    input  wire                irq_pnd,
    input  wire pm_pkg::word_t pc,
    input  wire pm_pkg::word_t r15,
    input  wire pm_pkg::word_t sm_data,
    input  wire pm_pkg::word_t sm_prev_id,
    input  wire                sm_data_select_valid,
    input  wire                caller_valid,
    output logic               busy,
    output pm_pkg::sm_req_t    sm_request,
    output pm_pkg::word_t      sm_data_select,
    output logic               mb_en,
    output logic [1:0]         mb_wr,
    output pm_pkg::addr_t      mab,
    output pm_pkg::word_t      data_out,
    output logic               reg_write,
    output pm_pkg::word_t      dest_reg,
    output pm_pkg::word_t      reg_data_out,
    output logic               stat_z,
    output logic               stat_wr
);

    logic sm_valid;
    logic range_done;
    logic walk_init;
    logic walk_limit_init;
    logic walk_inc;
    logic set_result;
    logic result_fail;

    // only clears are written
    assign data_out = '0;

    control_fsm u_fsm (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .cmd_id          (cmd_id),
        .cmd_id_prev     (cmd_id_prev),
        .cmd_disable     (cmd_disable),
        .irq_pnd         (irq_pnd),
        .sm_valid        (sm_valid),
        .range_done      (range_done),
        .busy            (busy),
        .sm_request      (sm_request),
        .walk_init       (walk_init),
        .walk_limit_init (walk_limit_init),
        .walk_inc        (walk_inc),
        .mb_en           (mb_en),
        .mb_wr           (mb_wr),
        .set_result      (set_result),
        .result_fail     (result_fail)
    );

    range_walker u_walker (
        .clk             (clk),
        .walk_init       (walk_init),
        .walk_limit_init (walk_limit_init),
        .walk_inc        (walk_inc),
        .sm_data         (sm_data),
        .mab             (mab),
        .range_done      (range_done)
    );

    sm_select u_select (
        .clk                  (clk),
        .reset                (reset),
        .cmd_id               (cmd_id),
        .cmd_id_prev          (cmd_id_prev),
        .cmd_disable          (cmd_disable),
        .sm_data_select_valid (sm_data_select_valid),
        .caller_valid         (caller_valid),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data_select       (sm_data_select),
        .sm_valid             (sm_valid)
    );

    result_writer u_result (
        .clk          (clk),
        .reset        (reset),
        .set_result   (set_result),
        .result_fail  (result_fail),
        .irq_pnd      (irq_pnd),
        .cmd_id_prev  (cmd_id_prev),
        .cmd_disable  (cmd_disable),
        .sm_data      (sm_data),
        .sm_prev_id   (sm_prev_id),
        .r15          (r15),
        .reg_write    (reg_write),
        .dest_reg     (dest_reg),
        .reg_data_out (reg_data_out),
        .stat_z       (stat_z),
        .stat_wr      (stat_wr)
    );

endmodule

`default_nettype wire

// ==== design/control_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_fsm (
    input  wire              clk,
    input  wire              reset,
    input  wire              start,
    input  wire              cmd_id,
    input  wire              cmd_id_prev,
    input  wire              cmd_disable,
    input  wire              irq_pnd,
    input  wire              sm_valid,
    input  wire              range_done,
    output logic             busy,
    output pm_pkg::sm_req_t  sm_request,
    output logic             walk_init,
    output logic             walk_limit_init,
    output logic             walk_inc,
    output logic             mb_en,
    output logic [1:0]       mb_wr,
    output logic             set_result,
    output logic             result_fail
);

    pm_pkg::ctrl_state_t state;
    pm_pkg::ctrl_state_t next_state;
    logic                irq_abort;

    // lookup and result states run to completion
    assign irq_abort = irq_pnd && (state != pm_pkg::IDLE) && (state != pm_pkg::CHECK_SM)
                       && (state != pm_pkg::FAIL) && (state != pm_pkg::SUCCESS);

    always_comb
    begin
        next_state = pm_pkg::IDLE;
        if (irq_abort)
            next_state = pm_pkg::FAIL;
        else
        begin
            case (state)
                pm_pkg::IDLE:
                    next_state = start ? pm_pkg::CHECK_SM : pm_pkg::IDLE;
                pm_pkg::CHECK_SM:
                begin
                    if (!sm_valid)
                        next_state = pm_pkg::FAIL;
                    else if (cmd_id || cmd_id_prev)
                        next_state = pm_pkg::SUCCESS;
                    else if (cmd_disable)
                        next_state = pm_pkg::CLEAR_CODE_INIT1;
                    else
                        next_state = pm_pkg::FAIL;
                end
                pm_pkg::CLEAR_CODE_INIT1: next_state = pm_pkg::CLEAR_CODE_INIT2;
                pm_pkg::CLEAR_CODE_INIT2: next_state = pm_pkg::CLEAR_CODE;
                pm_pkg::CLEAR_CODE:
                    next_state = range_done ? pm_pkg::CLEAR_DATA_INIT1 : pm_pkg::CLEAR_CODE;
                pm_pkg::CLEAR_DATA_INIT1: next_state = pm_pkg::CLEAR_DATA_INIT2;
                pm_pkg::CLEAR_DATA_INIT2: next_state = pm_pkg::CLEAR_DATA;
                pm_pkg::CLEAR_DATA:
                    next_state = range_done ? pm_pkg::SUCCESS : pm_pkg::CLEAR_DATA;
                pm_pkg::SUCCESS:
                    next_state = cmd_disable ? pm_pkg::WAIT : pm_pkg::IDLE;
                default:
                    next_state = pm_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= pm_pkg::IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        sm_request      = pm_pkg::REQ_NONE;
        walk_init       = 1'b0;
        walk_limit_init = 1'b0;
        walk_inc        = 1'b0;
        mb_en           = 1'b0;
        mb_wr           = 2'b00;
        set_result      = 1'b0;
        result_fail     = 1'b0;
        // range setup and writes belong to the state being entered
        case (next_state)
            pm_pkg::CLEAR_CODE_INIT1:
            begin
                sm_request = pm_pkg::REQ_PUB_START;
                walk_init  = 1'b1;
            end
            pm_pkg::CLEAR_CODE_INIT2:
            begin
                sm_request      = pm_pkg::REQ_PUB_END;
                walk_limit_init = 1'b1;
            end
            pm_pkg::CLEAR_DATA_INIT1:
            begin
                sm_request = pm_pkg::REQ_SEC_START;
                walk_init  = 1'b1;
            end
            pm_pkg::CLEAR_DATA_INIT2:
            begin
                sm_request      = pm_pkg::REQ_SEC_END;
                walk_limit_init = 1'b1;
            end
            pm_pkg::CLEAR_CODE, pm_pkg::CLEAR_DATA:
            begin
                mb_en    = 1'b1;
                mb_wr    = 2'b11;
                walk_inc = 1'b1;
            end
            default:
                ;
        endcase
        // result capture lines up with the id request of the current state
        if (state == pm_pkg::SUCCESS)
        begin
            set_result = 1'b1;
            if (cmd_id)
                sm_request = pm_pkg::REQ_ID;
        end
        else if (state == pm_pkg::FAIL)
        begin
            set_result  = 1'b1;
            result_fail = 1'b1;
        end
    end

    assign busy = (state != pm_pkg::IDLE);

endmodule

`default_nettype wire

// ==== design/result_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_writer (
    input  wire                clk,
    input  wire                reset,
    input  wire                set_result,
    input  wire                result_fail,
    input  wire                irq_pnd,
    input  wire                cmd_id_prev,
    input  wire                cmd_disable,
    input  wire pm_pkg::word_t sm_data,
    input  wire pm_pkg::word_t sm_prev_id,
    input  wire pm_pkg::word_t r15,
    output logic               reg_write,
    output pm_pkg::word_t      dest_reg,
    output pm_pkg::word_t      reg_data_out,
    output logic               stat_z,
    output logic               stat_wr
);

    pm_pkg::word_t dest_val;
    pm_pkg::word_t data_val;

    always_comb
    begin
        dest_val = pm_pkg::DEST_STATUS;
        data_val = sm_data;
        if (result_fail)
            data_val = pm_pkg::RESULT_FAIL;
        else if (cmd_disable)
        begin
            dest_val = pm_pkg::DEST_R1;
            data_val = r15;
        end
        else if (cmd_id_prev)
            data_val = sm_prev_id;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reg_write <= 1'b0;
            stat_wr   <= 1'b0;
            stat_z    <= 1'b0;
        end
        else
        begin
            reg_write <= set_result;
            stat_wr   <= set_result;
            // zero flag separates an irq abort from a failed lookup
            stat_z    <= set_result && result_fail && irq_pnd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (set_result)
        begin
            dest_reg     <= dest_val;
            reg_data_out <= data_val;
        end
    end

endmodule

`default_nettype wire

// ==== design/sm_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module sm_select (
    input  wire                clk,
    input  wire                reset,
    input  wire                cmd_id,
    input  wire                cmd_id_prev,
    input  wire                cmd_disable,
    input  wire                sm_data_select_valid,
    input  wire                caller_valid,
    input  wire pm_pkg::word_t pc,
    input  wire pm_pkg::word_t r15,
    output pm_pkg::word_t      sm_data_select,
    output logic               sm_valid
);

    logic id_ok;
    logic disable_ok;

    // disable looks up the caller, the queries look at r15
    always_comb
    begin
        if (cmd_disable)
            sm_data_select = pc;
        else
            sm_data_select = r15;
    end

    assign id_ok      = cmd_id && sm_data_select_valid;
    assign disable_ok = cmd_disable && caller_valid;

    // prev-caller query needs no lookup
    always_ff @(posedge clk)
    begin
        if (reset)
            sm_valid <= 1'b0;
        else
            sm_valid <= cmd_id_prev || id_ok || disable_ok;
    end

endmodule

`default_nettype wire

// ==== design/range_walker.sv ====
`timescale 1ns/100ps
`default_nettype none

module range_walker (
    input  wire                clk,
    input  wire                walk_init,
    input  wire                walk_limit_init,
    input  wire                walk_inc,
    input  wire pm_pkg::word_t sm_data,
    output pm_pkg::addr_t      mab,
    output logic               range_done
);

    pm_pkg::addr_t addr_q;
    pm_pkg::addr_t limit_q;

    // word address of the next write
    always_ff @(posedge clk)
    begin
        if (walk_init)
            addr_q <= pm_pkg::addr_t'(sm_data);
        else if (walk_inc)
            addr_q <= addr_q + pm_pkg::WORD_BYTES;
    end

    // end bound is exclusive
    always_ff @(posedge clk)
    begin
        if (walk_limit_init)
            limit_q <= pm_pkg::addr_t'(sm_data);
    end

    assign mab        = addr_q;
    assign range_done = (addr_q >= limit_q);

endmodule

`default_nettype wire

// ==== design/pm_pkg.sv ====
`default_nettype none

package pm_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;

    localparam addr_t WORD_BYTES = 16'd2;

    // destination codes for the result register
    localparam word_t DEST_STATUS = 16'h8000;
    localparam word_t DEST_R1     = 16'h0001;
    localparam word_t RESULT_FAIL = 16'h0000;

    // which table field sm_data carries
    typedef enum logic [2:0] {
        REQ_NONE      = 3'd0,
        REQ_PUB_START = 3'd1,
        REQ_PUB_END   = 3'd2,
        REQ_SEC_START = 3'd3,
        REQ_SEC_END   = 3'd4,
        REQ_ID        = 3'd5
    } sm_req_t;

    typedef enum logic [3:0] {
        IDLE,
        CHECK_SM,
        CLEAR_CODE_INIT1,
        CLEAR_CODE_INIT2,
        CLEAR_CODE,
        CLEAR_DATA_INIT1,
        CLEAR_DATA_INIT2,
        CLEAR_DATA,
        FAIL,
        SUCCESS,
        WAIT
    } ctrl_state_t;

endpackage

`default_nettype wire
